//--- Makefile
VERILATOR ?= verilator
FILELIST  ?= project.f
TB_TOP    ?= mips_cpu_bus_tb
RTL_TOP   ?= mips_cpu_bus
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TB_TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "^Test OK$$"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- project.f
+incdir+verilog
verilog/mips_isa_pkg.sv
verilog/cpu_ctrl_pkg.sv
verilog/decoder.sv
verilog/register_file.sv
verilog/alu.sv
verilog/next_pc.sv
verilog/mips_cpu_bus.sv
testbench/avalon_memory.sv
testbench/mips_cpu_bus_tb.sv

//--- testbench/avalon_memory.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module avalon_memory (
  input  logic                clk,
  input  mips_isa_pkg::word_t address,
  input  logic                read,
  input  logic                write,
  input  mips_isa_pkg::word_t writedata,
  output logic                waitrequest,
  output mips_isa_pkg::word_t readdata
);

  // 4 KB at the reset vector and 4 KB of low memory from zero
  mips_isa_pkg::word_t boot_mem [1024];
  mips_isa_pkg::word_t low_mem [1024];
  logic [1:0]          stall;

  function automatic logic in_boot(input mips_isa_pkg::word_t addr);
    return (addr & 32'hFFFFF000) == `CPU_RESET_VECTOR;
  endfunction

  task automatic write_word(input mips_isa_pkg::word_t addr, input mips_isa_pkg::word_t data);
    if (in_boot(addr)) boot_mem[addr[11:2]] = data;
    else if (addr < 32'h1000) low_mem[addr[11:2]] = data;
  endtask

  task automatic read_word(input mips_isa_pkg::word_t addr, output mips_isa_pkg::word_t data);
    if (in_boot(addr)) data = boot_mem[addr[11:2]];
    else if (addr < 32'h1000) data = low_mem[addr[11:2]];
    else data = '0;
  endtask

  task automatic clear_all();
    for (int i = 0; i < 1024; i++) begin
      boot_mem[i] = '0;
      low_mem[i]  = '0;
    end
  endtask

  // stall count for the access in progress is redrawn when one completes
  assign waitrequest = (read || write) && (stall != 2'd0);

  always_comb begin
    if (in_boot(address)) readdata = boot_mem[address[11:2]];
    else if (address < 32'h1000) readdata = low_mem[address[11:2]];
    else readdata = '0;
  end

  initial begin
    void'($urandom(32'h3565));
    stall <= 2'($urandom % 4);
    forever begin
      @(posedge clk);
      if (read || write) begin
        if (stall != 2'd0) begin
          stall <= stall - 2'd1;
        end else begin
          stall <= 2'($urandom % 4);
          if (write) write_word(address, writedata);
        end
      end
    end
  end

endmodule

//--- testbench/mips_cpu_bus_tb.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module mips_cpu_bus_tb;

  localparam int NUM_TESTS = 7;
  localparam int PROG_LEN  = 12;
  localparam int HALT_WAIT = 2000;

  logic                clk;
  logic                reset;
  logic                active;
  logic                read;
  logic                write;
  logic                waitrequest;
  mips_isa_pkg::word_t register_v0, address, writedata, readdata;

  // one row per test
  string               names [NUM_TESTS];
  mips_isa_pkg::word_t prog [NUM_TESTS][PROG_LEN];
  mips_isa_pkg::word_t exp_v0 [NUM_TESTS];
  logic                has_mem [NUM_TESTS];
  mips_isa_pkg::word_t mem_addr [NUM_TESTS];
  mips_isa_pkg::word_t mem_data [NUM_TESTS];

  int cur_row;
  int slot;
  int passed;
  int failed;
  logic row_bad;

  mips_cpu_bus uut (
    .clk(clk), .reset(reset), .active(active), .register_v0(register_v0),
    .address(address), .read(read), .write(write), .writedata(writedata),
    .waitrequest(waitrequest), .readdata(readdata)
  );

  avalon_memory mem (
    .clk(clk), .address(address), .read(read), .write(write),
    .writedata(writedata), .waitrequest(waitrequest), .readdata(readdata)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic mips_isa_pkg::instr_t build_r(input mips_isa_pkg::funct_t fn,
      input logic [4:0] rs, input logic [4:0] rt, input logic [4:0] rd,
      input logic [4:0] shamt);
    mips_isa_pkg::instr_t w;
    w.r_fmt.opcode = mips_isa_pkg::OP_SPECIAL;
    w.r_fmt.rs     = rs;
    w.r_fmt.rt     = rt;
    w.r_fmt.rd     = rd;
    w.r_fmt.shamt  = shamt;
    w.r_fmt.funct  = fn;
    return w;
  endfunction

  function automatic mips_isa_pkg::instr_t build_i(input mips_isa_pkg::opcode_t op,
      input logic [4:0] rs, input logic [4:0] rt, input logic [15:0] imm);
    mips_isa_pkg::instr_t w;
    w.i_fmt.opcode = op;
    w.i_fmt.rs     = rs;
    w.i_fmt.rt     = rt;
    w.i_fmt.imm    = imm;
    return w;
  endfunction

  function automatic mips_isa_pkg::instr_t build_j(input mips_isa_pkg::opcode_t op,
      input logic [25:0] target);
    mips_isa_pkg::instr_t w;
    w.j_fmt.opcode = op;
    w.j_fmt.target = target;
    return w;
  endfunction

  task automatic new_row(input string n, input mips_isa_pkg::word_t v0, input logic chk,
      input mips_isa_pkg::word_t addr, input mips_isa_pkg::word_t data);
    cur_row++;
    slot              = 0;
    names[cur_row]    = n;
    exp_v0[cur_row]   = v0;
    has_mem[cur_row]  = chk;
    mem_addr[cur_row] = addr;
    mem_data[cur_row] = data;
    for (int i = 0; i < PROG_LEN; i++) begin
      prog[cur_row][i] = '0;
    end
  endtask

  task automatic emit(input mips_isa_pkg::instr_t w);
    prog[cur_row][slot] = w;
    slot++;
  endtask

  task automatic fill_table();
    cur_row = -1;
    // addu subu slt sltu sll
    new_row("alu_arith", 32'h00000020, 1'b0, '0, '0);
    emit(build_i(mips_isa_pkg::OP_ADDIU, 5'd0, 5'd8, 16'd100));
    emit(build_i(mips_isa_pkg::OP_ADDIU, 5'd0, 5'd9, 16'hFFF9));
    emit(build_r(mips_isa_pkg::FN_ADDU, 5'd8, 5'd9, 5'd10, 5'd0));
    emit(build_r(mips_isa_pkg::FN_SUBU, 5'd8, 5'd9, 5'd11, 5'd0));
    emit(build_r(mips_isa_pkg::FN_SLT, 5'd9, 5'd8, 5'd12, 5'd0));
    emit(build_r(mips_isa_pkg::FN_SLTU, 5'd8, 5'd9, 5'd13, 5'd0));
    emit(build_r(mips_isa_pkg::FN_SUBU, 5'd11, 5'd10, 5'd2, 5'd0));
    emit(build_r(mips_isa_pkg::FN_SLL, 5'd0, 5'd12, 5'd12, 5'd4));
    emit(build_r(mips_isa_pkg::FN_ADDU, 5'd2, 5'd12, 5'd2, 5'd0));
    emit(build_r(mips_isa_pkg::FN_ADDU, 5'd2, 5'd13, 5'd2, 5'd0));
    emit(build_r(mips_isa_pkg::FN_JR, 5'd0, 5'd0, 5'd0, 5'd0));
    emit(build_i(mips_isa_pkg::OP_ADDIU, 5'd2, 5'd2, 16'd1));
    // and or xor sra srl
    new_row("alu_logic_shift", 32'hFFFFF10E, 1'b0, '0, '0);
    emit(build_i(mips_isa_pkg::OP_ADDIU, 5'd0, 5'd8, 16'h0F0F));
    emit(build_i(mips_isa_pkg::OP_ADDIU, 5'd0, 5'd9, 16'h00FF));
    emit(build_r(mips_isa_pkg::FN_AND, 5'd8, 5'd9, 5'd10, 5'd0));
    emit(build_r(mips_isa_pkg::FN_OR, 5'd8, 5'd9, 5'd11, 5'd0));
    emit(build_r(mips_isa_pkg::FN_XOR, 5'd11, 5'd10, 5'd12, 5'd0));
    emit(build_i(mips_isa_pkg::OP_ADDIU, 5'd0, 5'd13, 16'hFF00));
    emit(build_r(mips_isa_pkg::FN_SRA, 5'd0, 5'd13, 5'd14, 5'd4));
    emit(build_r(mips_isa_pkg::FN_SRL, 5'd0, 5'd13, 5'd15, 5'd24));
    emit(build_r(mips_isa_pkg::FN_XOR, 5'd14, 5'd12, 5'd2, 5'd0));
    emit(build_r(mips_isa_pkg::FN_ADDU, 5'd2, 5'd15, 5'd2, 5'd0));
    emit(build_r(mips_isa_pkg::FN_JR, 5'd0, 5'd0, 5'd0, 5'd0));
    emit(build_r(mips_isa_pkg::FN_ADDU, 5'd2, 5'd10, 5'd2, 5'd0));
    // sign and zero extension of immediates
    new_row("immediates", 32'h12358765, 1'b0, '0, '0);
    emit(build_i(mips_isa_pkg::OP_LUI, 5'd0, 5'd8, 16'h1234));
    emit(build_i(mips_isa_pkg::OP_ORI, 5'd8, 5'd8, 16'h8765));
    emit(build_i(mips_isa_pkg::OP_ADDIU, 5'd0, 5'd9, 16'h8000));
    emit(build_i(mips_isa_pkg::OP_SLTI, 5'd9, 5'd10, 16'hFFFF));
    emit(build_i(mips_isa_pkg::OP_SLTI, 5'd0, 5'd11, 16'h8000));
    emit(build_i(mips_isa_pkg::OP_ANDI, 5'd9, 5'd12, 16'hFFFF));
    emit(build_i(mips_isa_pkg::OP_XORI, 5'd0, 5'd13, 16'h8001));
    emit(build_r(mips_isa_pkg::FN_ADDU, 5'd8, 5'd12, 5'd2, 5'd0));
    emit(build_r(mips_isa_pkg::FN_XOR, 5'd2, 5'd13, 5'd2, 5'd0));
    emit(build_r(mips_isa_pkg::FN_ADDU, 5'd2, 5'd10, 5'd2, 5'd0));
    emit(build_r(mips_isa_pkg::FN_JR, 5'd0, 5'd0, 5'd0, 5'd0));
    emit(build_r(mips_isa_pkg::FN_ADDU, 5'd2, 5'd11, 5'd2, 5'd0));
    // store then load back, base register r9 = 0x200
    new_row("load_store", 32'hCAFEF062, 1'b1, 32'h00000210, 32'hCAFEF00D);
    emit(build_i(mips_isa_pkg::OP_LUI, 5'd0, 5'd8, 16'hCAFE));
    emit(build_i(mips_isa_pkg::OP_ORI, 5'd8, 5'd8, 16'hF00D));
    emit(build_i(mips_isa_pkg::OP_ADDIU, 5'd0, 5'd9, 16'h0200));
    emit(build_i(mips_isa_pkg::OP_SW, 5'd9, 5'd8, 16'd16));
    emit(build_i(mips_isa_pkg::OP_LW, 5'd9, 5'd2, 16'd16));
    emit(build_i(mips_isa_pkg::OP_ADDIU, 5'd0, 5'd10, 16'h0055));
    emit(build_i(mips_isa_pkg::OP_SW, 5'd9, 5'd10, 16'd4));
    emit(build_i(mips_isa_pkg::OP_LW, 5'd9, 5'd11, 16'd4));
    emit(build_r(mips_isa_pkg::FN_ADDU, 5'd2, 5'd11, 5'd2, 5'd0));
    emit(build_r(mips_isa_pkg::FN_JR, 5'd0, 5'd0, 5'd0, 5'd0));
    // beq taken skips +0x10, then not taken runs +0x20
    new_row("branch_beq", 32'h00000027, 1'b0, '0, '0);
    emit(build_i(mips_isa_pkg::OP_ADDIU, 5'd0, 5'd8, 16'd5));
    emit(build_i(mips_isa_pkg::OP_BEQ, 5'd8, 5'd8, 16'd2));
    emit(build_i(mips_isa_pkg::OP_ADDIU, 5'd2, 5'd2, 16'h0001));
    emit(build_i(mips_isa_pkg::OP_ADDIU, 5'd2, 5'd2, 16'h0010));
    emit(build_i(mips_isa_pkg::OP_BEQ, 5'd8, 5'd0, 16'd2));
    emit(build_i(mips_isa_pkg::OP_ADDIU, 5'd2, 5'd2, 16'h0002));
    emit(build_i(mips_isa_pkg::OP_ADDIU, 5'd2, 5'd2, 16'h0020));
    emit(build_r(mips_isa_pkg::FN_JR, 5'd0, 5'd0, 5'd0, 5'd0));
    emit(build_i(mips_isa_pkg::OP_ADDIU, 5'd2, 5'd2, 16'h0004));
    new_row("branch_bne", 32'h00000063, 1'b0, '0, '0);
    emit(build_i(mips_isa_pkg::OP_ADDIU, 5'd0, 5'd8, 16'd5));
    emit(build_i(mips_isa_pkg::OP_BNE, 5'd8, 5'd0, 16'd2));
    emit(build_i(mips_isa_pkg::OP_ADDIU, 5'd2, 5'd2, 16'h0001));
    emit(build_i(mips_isa_pkg::OP_ADDIU, 5'd2, 5'd2, 16'h0010));
    emit(build_i(mips_isa_pkg::OP_BNE, 5'd8, 5'd8, 16'd2));
    emit(build_i(mips_isa_pkg::OP_ADDIU, 5'd2, 5'd2, 16'h0002));
    emit(build_i(mips_isa_pkg::OP_ADDIU, 5'd2, 5'd2, 16'h0020));
    emit(build_r(mips_isa_pkg::FN_JR, 5'd0, 5'd0, 5'd0, 5'd0));
    emit(build_i(mips_isa_pkg::OP_ADDIU, 5'd2, 5'd2, 16'h0040));
    // jal to slot 6, jalr to slot 10; v0 = 1 + link(jal) + link(jalr)
    new_row("jumps", 32'h7F800021, 1'b0, '0, '0);
    emit(build_i(mips_isa_pkg::OP_LUI, 5'd0, 5'd12, 16'hBFC0));
    emit(build_j(mips_isa_pkg::OP_JAL, 26'h3F00006));
    emit(build_i(mips_isa_pkg::OP_ORI, 5'd12, 5'd12, 16'h0028));
    emit(build_r(mips_isa_pkg::FN_JALR, 5'd12, 5'd0, 5'd10, 5'd0));
    emit(build_r(mips_isa_pkg::FN_ADDU, 5'd2, 5'd31, 5'd2, 5'd0));
    emit(build_i(mips_isa_pkg::OP_ADDIU, 5'd2, 5'd2, 16'h0100));
    emit(build_r(mips_isa_pkg::FN_JR, 5'd31, 5'd0, 5'd0, 5'd0));
    emit(build_i(mips_isa_pkg::OP_ADDIU, 5'd2, 5'd2, 16'h0001));
    emit(build_i(mips_isa_pkg::OP_ADDIU, 5'd2, 5'd2, 16'h0200));
    emit(build_i(mips_isa_pkg::OP_ADDIU, 5'd2, 5'd2, 16'h0400));
    emit(build_r(mips_isa_pkg::FN_JR, 5'd0, 5'd0, 5'd0, 5'd0));
    emit(build_r(mips_isa_pkg::FN_ADDU, 5'd2, 5'd10, 5'd2, 5'd0));
  endtask

  task automatic check_word(input string name, input mips_isa_pkg::word_t expected,
      input mips_isa_pkg::word_t actual);
    if (actual !== expected) begin
      $display("FAILED %s: expected %h, got %h", name, expected, actual);
      row_bad = 1'b1;
    end
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("FAILED %s: expected %h, got %h", name, expected, actual);
      row_bad = 1'b1;
    end
  endtask

  task automatic run_row(input int t);
    mips_isa_pkg::word_t stored;
    int cycles;
    row_bad = 1'b0;
    mem.clear_all();
    for (int i = 0; i < PROG_LEN; i++) begin
      mem.write_word(`CPU_RESET_VECTOR + 32'(4 * i), prog[t][i]);
    end
    // nop at the halt address
    mem.write_word(`CPU_HALT_ADDR, 32'h00000000);
    @(posedge clk);
    reset <= 1'b1;
    repeat (10) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    check_bit("active", 1'b1, active);
    cycles = 0;
    while (active === 1'b1 && cycles < HALT_WAIT) begin
      @(negedge clk);
      cycles++;
    end
    if (active === 1'b1) begin
      $display("ERROR %s: the processor never halted within %0d cycles", names[t], HALT_WAIT);
      row_bad = 1'b1;
    end else begin
      check_word("register_v0", exp_v0[t], register_v0);
      if (has_mem[t]) begin
        mem.read_word(mem_addr[t], stored);
        check_word("memory word", mem_data[t], stored);
      end
      repeat (20) @(negedge clk);
      check_bit("active after halt", 1'b0, active);
      check_word("register_v0 after halt", exp_v0[t], register_v0);
    end
    if (row_bad) begin
      $display("test %s: failed", names[t]);
      failed++;
    end else begin
      $display("test %s: passed", names[t]);
      passed++;
    end
  endtask

  initial begin
    reset  = 1'b1;
    passed = 0;
    failed = 0;
    fill_table();
    for (int t = 0; t < NUM_TESTS; t++) begin
      run_row(t);
    end
    $display("%0d tests passed, %0d failed", passed, failed);
    if (failed == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

//--- verilog/alu.sv
`timescale 1ns/1ps

module alu (
  input  cpu_ctrl_pkg::alu_op_t alu_op,
  input  mips_isa_pkg::word_t   a,
  input  mips_isa_pkg::word_t   b,
  input  logic [4:0]            shamt,
  output mips_isa_pkg::word_t   result,
  output logic                  equal
);

  always_comb begin
    case (alu_op)
      cpu_ctrl_pkg::ALU_ADD:  result = a + b;
      cpu_ctrl_pkg::ALU_SUB:  result = a - b;
      cpu_ctrl_pkg::ALU_AND:  result = a & b;
      cpu_ctrl_pkg::ALU_OR:   result = a | b;
      cpu_ctrl_pkg::ALU_XOR:  result = a ^ b;
      cpu_ctrl_pkg::ALU_SLT:  result = {31'd0, $signed(a) < $signed(b)};
      cpu_ctrl_pkg::ALU_SLTU: result = {31'd0, a < b};
      // shifts act on rt, which arrives as b
      cpu_ctrl_pkg::ALU_SLL:  result = b << shamt;
      cpu_ctrl_pkg::ALU_SRL:  result = b >> shamt;
      cpu_ctrl_pkg::ALU_SRA:  result = $signed(b) >>> shamt;
      cpu_ctrl_pkg::ALU_LUI:  result = {b[15:0], 16'h0000};
      default:                result = '0;
    endcase
  end

  // rs against rt for beq and bne
  assign equal = (a == b);

endmodule

//--- verilog/cpu_ctrl_pkg.sv
package cpu_ctrl_pkg;

  // multicycle sequence, one pass per instruction
  typedef enum logic [1:0] {
    FETCH  = 2'd0,
    EXEC   = 2'd1,
    MEM    = 2'd2,
    HALTED = 2'd3
  } cpu_state_t;

  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLT  = 4'd5,
    ALU_SLTU = 4'd6,
    ALU_SLL  = 4'd7,
    ALU_SRL  = 4'd8,
    ALU_SRA  = 4'd9,
    ALU_LUI  = 4'd10
  } alu_op_t;

  // register write-back source, link is pc plus 8
  typedef enum logic [1:0] {
    WB_ALU  = 2'd0,
    WB_MEM  = 2'd1,
    WB_LINK = 2'd2
  } wb_src_t;

endpackage

//--- verilog/cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// first fetch address after reset, in the boot region
`define CPU_RESET_VECTOR 32'hBFC00000

// executing the instruction fetched here ends a run
`define CPU_HALT_ADDR 32'h00000000

// general purpose registers, r0 hardwired to zero
`define CPU_NUM_REGS 32

`endif

//--- verilog/decoder.sv
`timescale 1ns/1ps

module decoder (
  input  mips_isa_pkg::instr_t   instr,
  output cpu_ctrl_pkg::alu_op_t  alu_op,
  output logic                   alu_imm,
  output logic                   imm_zero_ext,
  output logic                   reg_write_en,
  output logic                   mem_read,
  output logic                   mem_write,
  output logic                   branch_eq,
  output logic                   branch_ne,
  output logic                   jump_imm,
  output logic                   jump_reg,
  output cpu_ctrl_pkg::wb_src_t  wb_src,
  output logic [4:0]             dest_reg
);

  always_comb begin
    // no-op unless a supported code says otherwise
    alu_op       = cpu_ctrl_pkg::ALU_ADD;
    alu_imm      = 1'b0;
    imm_zero_ext = 1'b0;
    reg_write_en = 1'b0;
    mem_read     = 1'b0;
    mem_write    = 1'b0;
    branch_eq    = 1'b0;
    branch_ne    = 1'b0;
    jump_imm     = 1'b0;
    jump_reg     = 1'b0;
    wb_src       = cpu_ctrl_pkg::WB_ALU;
    dest_reg     = instr.i_fmt.rt;

    case (instr.r_fmt.opcode)
      mips_isa_pkg::OP_SPECIAL: begin
        dest_reg     = instr.r_fmt.rd;
        reg_write_en = 1'b1;
        case (instr.r_fmt.funct)
          mips_isa_pkg::FN_ADDU: alu_op = cpu_ctrl_pkg::ALU_ADD;
          mips_isa_pkg::FN_SUBU: alu_op = cpu_ctrl_pkg::ALU_SUB;
          mips_isa_pkg::FN_AND:  alu_op = cpu_ctrl_pkg::ALU_AND;
          mips_isa_pkg::FN_OR:   alu_op = cpu_ctrl_pkg::ALU_OR;
          mips_isa_pkg::FN_XOR:  alu_op = cpu_ctrl_pkg::ALU_XOR;
          mips_isa_pkg::FN_SLT:  alu_op = cpu_ctrl_pkg::ALU_SLT;
          mips_isa_pkg::FN_SLTU: alu_op = cpu_ctrl_pkg::ALU_SLTU;
          mips_isa_pkg::FN_SLL:  alu_op = cpu_ctrl_pkg::ALU_SLL;
          mips_isa_pkg::FN_SRL:  alu_op = cpu_ctrl_pkg::ALU_SRL;
          mips_isa_pkg::FN_SRA:  alu_op = cpu_ctrl_pkg::ALU_SRA;
          mips_isa_pkg::FN_JR: begin
            jump_reg     = 1'b1;
            reg_write_en = 1'b0;
          end
          mips_isa_pkg::FN_JALR: begin
            jump_reg = 1'b1;
            wb_src   = cpu_ctrl_pkg::WB_LINK;
          end
          default: reg_write_en = 1'b0;
        endcase
      end
      mips_isa_pkg::OP_J:   jump_imm = 1'b1;
      mips_isa_pkg::OP_JAL: begin
        jump_imm     = 1'b1;
        reg_write_en = 1'b1;
        wb_src       = cpu_ctrl_pkg::WB_LINK;
        dest_reg     = 5'd31;
      end
      mips_isa_pkg::OP_BEQ: branch_eq = 1'b1;
      mips_isa_pkg::OP_BNE: branch_ne = 1'b1;
      mips_isa_pkg::OP_ADDIU, mips_isa_pkg::OP_SLTI: begin
        alu_imm      = 1'b1;
        reg_write_en = 1'b1;
        alu_op       = (instr.i_fmt.opcode == mips_isa_pkg::OP_SLTI) ?
                       cpu_ctrl_pkg::ALU_SLT : cpu_ctrl_pkg::ALU_ADD;
      end
      mips_isa_pkg::OP_ANDI, mips_isa_pkg::OP_ORI, mips_isa_pkg::OP_XORI,
      mips_isa_pkg::OP_LUI: begin
        alu_imm      = 1'b1;
        imm_zero_ext = 1'b1;
        reg_write_en = 1'b1;
        case (instr.i_fmt.opcode)
          mips_isa_pkg::OP_ANDI: alu_op = cpu_ctrl_pkg::ALU_AND;
          mips_isa_pkg::OP_ORI:  alu_op = cpu_ctrl_pkg::ALU_OR;
          mips_isa_pkg::OP_XORI: alu_op = cpu_ctrl_pkg::ALU_XOR;
          default:               alu_op = cpu_ctrl_pkg::ALU_LUI;
        endcase
      end
      mips_isa_pkg::OP_LW: begin
        alu_imm      = 1'b1;
        mem_read     = 1'b1;
        reg_write_en = 1'b1;
        wb_src       = cpu_ctrl_pkg::WB_MEM;
      end
      mips_isa_pkg::OP_SW: begin
        alu_imm   = 1'b1;
        mem_write = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

//--- verilog/mips_cpu_bus.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module mips_cpu_bus (
  input  logic                clk,
  input  logic                reset,
  output logic                active,
  output mips_isa_pkg::word_t register_v0,
  output mips_isa_pkg::word_t address,
  output logic                read,
  output logic                write,
  output mips_isa_pkg::word_t writedata,
  input  logic                waitrequest,
  input  mips_isa_pkg::word_t readdata
);

  cpu_ctrl_pkg::cpu_state_t state;
  mips_isa_pkg::instr_t     ir;
  logic                     wake;

  cpu_ctrl_pkg::alu_op_t alu_op;
  cpu_ctrl_pkg::wb_src_t wb_src;
  logic       alu_imm, imm_zero_ext, reg_write_en, mem_read, mem_write;
  logic       branch_eq, branch_ne, jump_imm, jump_reg;
  logic [4:0] dest_reg;

  mips_isa_pkg::word_t rs_value, rt_value, imm_ext, alu_b, alu_result;
  mips_isa_pkg::word_t wb_data, pc, pc_plus8;
  logic                equal, mem_access, at_halt, pc_step, reg_write;

  assign mem_access = mem_read || mem_write;
  assign at_halt    = (pc == `CPU_HALT_ADDR);

  // bus side is idle for one cycle out of reset
  assign read      = (state == cpu_ctrl_pkg::FETCH && !wake) ||
                     (state == cpu_ctrl_pkg::MEM && mem_read);
  assign write     = (state == cpu_ctrl_pkg::MEM) && mem_write;
  assign address   = (state == cpu_ctrl_pkg::MEM) ? alu_result : pc;
  assign writedata = rt_value;
  assign active    = (state != cpu_ctrl_pkg::HALTED);

  // end of instruction and register write strobes
  assign pc_step   = (state == cpu_ctrl_pkg::EXEC && !mem_access) ||
                     (state == cpu_ctrl_pkg::MEM && !waitrequest);
  assign reg_write = reg_write_en &&
                     ((state == cpu_ctrl_pkg::EXEC && !mem_access) ||
                      (state == cpu_ctrl_pkg::MEM && mem_read && !waitrequest));

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= cpu_ctrl_pkg::FETCH;
      wake  <= 1'b1;
    end else begin
      wake <= 1'b0;
      case (state)
        cpu_ctrl_pkg::FETCH:
          if (read && !waitrequest) state <= cpu_ctrl_pkg::EXEC;
        cpu_ctrl_pkg::EXEC:
          if (mem_access) state <= cpu_ctrl_pkg::MEM;
          else state <= at_halt ? cpu_ctrl_pkg::HALTED : cpu_ctrl_pkg::FETCH;
        cpu_ctrl_pkg::MEM:
          if (!waitrequest) state <= at_halt ? cpu_ctrl_pkg::HALTED : cpu_ctrl_pkg::FETCH;
        default:
          state <= cpu_ctrl_pkg::HALTED;
      endcase
    end
  end

  // instruction register
  always_ff @(posedge clk) begin
    if (state == cpu_ctrl_pkg::FETCH && read && !waitrequest) ir <= readdata;
  end

  assign imm_ext = imm_zero_ext ? {16'h0000, ir.i_fmt.imm}
                                : {{16{ir.i_fmt.imm[15]}}, ir.i_fmt.imm};
  assign alu_b   = alu_imm ? imm_ext : rt_value;

  always_comb begin
    case (wb_src)
      cpu_ctrl_pkg::WB_MEM:  wb_data = readdata;
      cpu_ctrl_pkg::WB_LINK: wb_data = pc_plus8;
      default:               wb_data = alu_result;
    endcase
  end

  decoder u_decoder (
    .instr(ir), .alu_op(alu_op), .alu_imm(alu_imm), .imm_zero_ext(imm_zero_ext),
    .reg_write_en(reg_write_en), .mem_read(mem_read), .mem_write(mem_write),
    .branch_eq(branch_eq), .branch_ne(branch_ne), .jump_imm(jump_imm),
    .jump_reg(jump_reg), .wb_src(wb_src), .dest_reg(dest_reg)
  );

  register_file u_register_file (
    .clk(clk), .reset(reset), .write_en(reg_write),
    .read_reg_a(ir.r_fmt.rs), .read_reg_b(ir.r_fmt.rt), .write_reg(dest_reg),
    .write_data(wb_data), .read_data_a(rs_value), .read_data_b(rt_value),
    .register_v0(register_v0)
  );

  alu u_alu (
    .alu_op(alu_op), .a(rs_value), .b(alu_b), .shamt(ir.r_fmt.shamt),
    .result(alu_result), .equal(equal)
  );

  next_pc u_next_pc (
    .clk(clk), .reset(reset), .pc_step(pc_step), .instr(ir), .rs_value(rs_value),
    .equal(equal), .branch_eq(branch_eq), .branch_ne(branch_ne),
    .jump_imm(jump_imm), .jump_reg(jump_reg), .pc(pc), .pc_plus8(pc_plus8)
  );

  a_bus_exclusive: assert property (@(posedge clk) disable iff (reset) !(read && write));

  // fetch and data addresses come from different units
  a_bus_aligned: assert property (@(posedge clk) disable iff (reset)
    (read || write) |-> address[1:0] == 2'b00);

  // a stalled access keeps its request, address and data until it completes
  a_bus_hold: assert property (@(posedge clk) disable iff (reset)
    (read || write) && waitrequest |=>
      $stable(read) && $stable(write) && $stable(address) && $stable(writedata));

endmodule

//--- verilog/mips_isa_pkg.sv
package mips_isa_pkg;

  typedef logic [31:0] word_t;

  // register format
  typedef struct packed {
    logic [5:0] opcode;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] shamt;
    logic [5:0] funct;
  } r_fmt_t;

  // immediate format, also loads, stores and branches
  typedef struct packed {
    logic [5:0]  opcode;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [15:0] imm;
  } i_fmt_t;

  // j and jal
  typedef struct packed {
    logic [5:0]  opcode;
    logic [25:0] target;
  } j_fmt_t;

  // one fetched word, seen three ways
  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    j_fmt_t j_fmt;
  } instr_t;

  typedef enum logic [5:0] {
    OP_SPECIAL = 6'h00,
    OP_J       = 6'h02,
    OP_JAL     = 6'h03,
    OP_BEQ     = 6'h04,
    OP_BNE     = 6'h05,
    OP_ADDIU   = 6'h09,
    OP_SLTI    = 6'h0A,
    OP_ANDI    = 6'h0C,
    OP_ORI     = 6'h0D,
    OP_XORI    = 6'h0E,
    OP_LUI     = 6'h0F,
    OP_LW      = 6'h23,
    OP_SW      = 6'h2B
  } opcode_t;

  // function field under OP_SPECIAL
  typedef enum logic [5:0] {
    FN_SLL  = 6'h00,
    FN_SRL  = 6'h02,
    FN_SRA  = 6'h03,
    FN_JR   = 6'h08,
    FN_JALR = 6'h09,
    FN_ADDU = 6'h21,
    FN_SUBU = 6'h23,
    FN_AND  = 6'h24,
    FN_OR   = 6'h25,
    FN_XOR  = 6'h26,
    FN_SLT  = 6'h2A,
    FN_SLTU = 6'h2B
  } funct_t;

endpackage

//--- verilog/next_pc.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module next_pc (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 pc_step,
  input  mips_isa_pkg::instr_t instr,
  input  mips_isa_pkg::word_t  rs_value,
  input  logic                 equal,
  input  logic                 branch_eq,
  input  logic                 branch_ne,
  input  logic                 jump_imm,
  input  logic                 jump_reg,
  output mips_isa_pkg::word_t  pc,
  output mips_isa_pkg::word_t  pc_plus8
);

  mips_isa_pkg::word_t pc_plus4, branch_target, jump_target, new_target, held_target;
  logic                taken, pending;

  assign pc_plus4 = pc + 32'd4;
  assign pc_plus8 = pc + 32'd8;

  // offset counted in words from the delay slot
  assign branch_target = pc_plus4 + {{14{instr.i_fmt.imm[15]}}, instr.i_fmt.imm, 2'b00};
  assign jump_target   = {pc_plus4[31:28], instr.j_fmt.target, 2'b00};

  assign taken = (branch_eq && equal) || (branch_ne && !equal) || jump_imm || jump_reg;

  always_comb begin
    if (jump_reg) new_target = rs_value;
    else if (jump_imm) new_target = jump_target;
    else new_target = branch_target;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc      <= `CPU_RESET_VECTOR;
      pending <= 1'b0;
    end else if (pc_step) begin
      // delay slot runs first, then the held target
      pc      <= pending ? held_target : pc_plus4;
      pending <= taken;
    end
  end

  always_ff @(posedge clk) begin
    if (pc_step && taken) held_target <= new_target;
  end

  a_pc_aligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00);

endmodule

//--- verilog/register_file.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module register_file (
  input  logic                clk,
  input  logic                reset,
  input  logic                write_en,
  input  logic [4:0]          read_reg_a,
  input  logic [4:0]          read_reg_b,
  input  logic [4:0]          write_reg,
  input  mips_isa_pkg::word_t write_data,
  output mips_isa_pkg::word_t read_data_a,
  output mips_isa_pkg::word_t read_data_b,
  output mips_isa_pkg::word_t register_v0
);

  mips_isa_pkg::word_t regs [`CPU_NUM_REGS];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `CPU_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (write_en && write_reg != 5'd0) begin
      regs[write_reg] <= write_data;
    end
  end

  // r0 reads zero whatever the array holds
  assign read_data_a = (read_reg_a == 5'd0) ? '0 : regs[read_reg_a];
  assign read_data_b = (read_reg_b == 5'd0) ? '0 : regs[read_reg_b];

  // v0 is r2, the result register
  assign register_v0 = regs[2];

endmodule
